// File: logic/mix_search_pkg.sv
`default_nettype none

package mix_search_pkg;

  ////////////////////
  // widths

  localparam int SAMPLE_W = 16;             // adc capture word
  localparam int REF_W    = 48;             // sine/cosine table word
  localparam int PROD_W   = SAMPLE_W + REF_W;
  localparam int ADDR_W   = 9;
  localparam int PHASE_W  = 12;
  localparam int SUM_W    = PROD_W + 10;    // guard bits for 1024 beats

  ////////////////////
  // scalar types

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [REF_W-1:0]    ref_t;
  typedef logic signed [PROD_W-1:0]   prod_t;
  typedef logic        [ADDR_W-1:0]   addr_t;
  typedef logic        [PHASE_W-1:0]  phase_t;
  typedef logic signed [SUM_W-1:0]    sum_t;

  ////////////////////
  // bundles

  // one mixed beat, both channels share the framing
  typedef struct packed {
    logic  valid;
    logic  sof;
    logic  eof;
    prod_t sine_prod;
    prod_t cosine_prod;
  } mix_beat_t;

  typedef struct packed {
    logic valid;                            // one cycle per frame
    sum_t sum;
  } frame_sum_t;

  typedef struct packed {
    phase_t max_pos;
    phase_t min_pos;
  } extremum_t;

endpackage

`default_nettype wire

// File: logic/ref_mixer.sv
`timescale 1ns/100ps
`default_nettype none

module ref_mixer (
  input  wire                          alg_clk,
  input  wire                          alg_rst_n,
  input  wire                          sine_valid,
  input  wire                          cosine_valid,
  input  wire mix_search_pkg::ref_t    sine_wave,
  input  wire mix_search_pkg::ref_t    cosine_wave,
  input  wire mix_search_pkg::sample_t capture_raw_dat,
  output wire                          search_req,
  output mix_search_pkg::addr_t        search_addr,
  output mix_search_pkg::mix_beat_t    beat
);

  logic                  valid_q;           // lines up with returning sample
  mix_search_pkg::ref_t  sine_wave_q;
  mix_search_pkg::ref_t  cosine_wave_q;
  logic                  prod_valid;
  logic                  prod_sof;
  logic                  prod_eof;
  mix_search_pkg::prod_t sine_prod;
  mix_search_pkg::prod_t cosine_prod;

  assign search_req = sine_valid;

  // beat k reads address k, counter parks at 0 between frames
  always_ff @(posedge alg_clk or negedge alg_rst_n)
  begin
    if (!alg_rst_n)
      search_addr <= '0;
    else if (search_req)
      search_addr <= search_addr + 1'b1;
    else
      search_addr <= '0;
  end

  ////////////////////
  // framing

  always_ff @(posedge alg_clk or negedge alg_rst_n)
  begin
    if (!alg_rst_n)
    begin
      valid_q    <= 1'b0;
      prod_valid <= 1'b0;
      prod_sof   <= 1'b0;
      prod_eof   <= 1'b0;
    end
    else
    begin
      valid_q    <= sine_valid;
      prod_valid <= valid_q;
      prod_sof   <= valid_q & ~prod_valid;  // rising edge of delayed valid
      prod_eof   <= valid_q & ~sine_valid;  // input already dropped
    end
  end

  ////////////////////
  // mixing

  always_ff @(posedge alg_clk)
  begin
    sine_wave_q   <= sine_wave;
    cosine_wave_q <= cosine_wave;
    if (valid_q)
    begin
      sine_prod   <= capture_raw_dat * sine_wave_q;   // signed 16x48
      cosine_prod <= capture_raw_dat * cosine_wave_q;
    end
  end

  assign beat = mix_search_pkg::mix_beat_t'{valid:       prod_valid,
                                            sof:         prod_sof,
                                            eof:         prod_eof,
                                            sine_prod:   sine_prod,
                                            cosine_prod: cosine_prod};

  // both reference channels are framed by one source
  ref_valid_match: assert property (@(posedge alg_clk) disable iff (!alg_rst_n)
    sine_valid == cosine_valid);

endmodule

`default_nettype wire

// File: logic/product_accumulator.sv
`timescale 1ns/100ps
`default_nettype none

module product_accumulator (
  input  wire                         alg_clk,
  input  wire                         alg_rst_n,
  input  wire                         beat_valid,
  input  wire                         beat_sof,
  input  wire                         beat_eof,
  input  wire mix_search_pkg::prod_t  prod,
  output mix_search_pkg::frame_sum_t  frame_sum
);

  mix_search_pkg::sum_t acc;
  mix_search_pkg::sum_t acc_next;
  mix_search_pkg::sum_t total;
  logic                 total_valid;
  logic                 frame_open;         // between sof and eof

  // sof starts over from this product alone
  assign acc_next = beat_sof ? mix_search_pkg::sum_t'(prod)
                             : acc + mix_search_pkg::sum_t'(prod);

  always_ff @(posedge alg_clk)
  begin
    if (beat_valid)
      acc <= acc_next;
    if (beat_valid && beat_eof)
      total <= acc_next;                    // includes the last beat
  end

  always_ff @(posedge alg_clk or negedge alg_rst_n)
  begin
    if (!alg_rst_n)
    begin
      total_valid <= 1'b0;
      frame_open  <= 1'b0;
    end
    else
    begin
      total_valid <= beat_valid & beat_eof;
      if (beat_valid && beat_eof)
        frame_open <= 1'b0;
      else if (beat_valid && beat_sof)
        frame_open <= 1'b1;
    end
  end

  assign frame_sum = mix_search_pkg::frame_sum_t'{valid: total_valid, sum: total};

  // a new frame may not start before the previous one closed
  sof_in_closed_frame: assert property (@(posedge alg_clk) disable iff (!alg_rst_n)
    beat_valid && beat_sof |-> !frame_open);

endmodule

`default_nettype wire

// File: logic/extremum_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module extremum_tracker (
  input  wire                             alg_clk,
  input  wire                             alg_rst_n,
  input  wire mix_search_pkg::frame_sum_t frame_sum,
  input  wire mix_search_pkg::phase_t     phase_idx,
  input  wire                             sweep_start,
  output mix_search_pkg::extremum_t       extremum
);

  mix_search_pkg::sum_t   sum_in;
  mix_search_pkg::sum_t   max_sum;
  mix_search_pkg::sum_t   min_sum;
  mix_search_pkg::phase_t max_pos;
  mix_search_pkg::phase_t min_pos;
  logic                   loaded;           // some frame seen since reset
  logic                   take_max;
  logic                   take_min;

  assign sum_in = frame_sum.sum;

  // first frame of a sweep loads both, ties keep the older position
  assign take_max = frame_sum.valid & (sweep_start | (sum_in > max_sum));
  assign take_min = frame_sum.valid & (sweep_start | (sum_in < min_sum));

  ////////////////////
  // running values

  always_ff @(posedge alg_clk)
  begin
    if (take_max)
      max_sum <= sum_in;
    if (take_min)
      min_sum <= sum_in;
  end

  ////////////////////
  // positions

  always_ff @(posedge alg_clk or negedge alg_rst_n)
  begin
    if (!alg_rst_n)
    begin
      max_pos <= '0;
      min_pos <= '0;
      loaded  <= 1'b0;
    end
    else
    begin
      if (take_max)
        max_pos <= phase_idx;               // index of the frame just summed
      if (take_min)
        min_pos <= phase_idx;
      if (frame_sum.valid)
        loaded <= 1'b1;
    end
  end

  assign extremum = mix_search_pkg::extremum_t'{max_pos: max_pos, min_pos: min_pos};

  // max and min are loaded together, so they can never cross
  max_not_below_min: assert property (@(posedge alg_clk) disable iff (!alg_rst_n)
    loaded |-> max_sum >= min_sum);

endmodule

`default_nettype wire

// File: logic/phase_sweep_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module phase_sweep_ctrl #(
  parameter int PHASE_STEPS = 3600
) (
  input  wire                     alg_clk,
  input  wire                     alg_rst_n,
  input  wire                     sum_valid,
  input  wire                     research,
  output mix_search_pkg::phase_t  phase_idx,
  output logic                    sweep_start,
  output logic                    frame_done,
  output wire                     sweep_found_pulse
);

  logic wrap;                               // current frame is the last step
  logic sweep_found;
  logic sweep_found_q;

  assign wrap = (phase_idx == mix_search_pkg::phase_t'(PHASE_STEPS - 1));

  always_ff @(posedge alg_clk or negedge alg_rst_n)
  begin
    if (!alg_rst_n)
    begin
      phase_idx   <= '0;
      sweep_start <= 1'b1;                  // first frame after reset opens a sweep
      frame_done  <= 1'b0;
    end
    else
    begin
      frame_done <= sum_valid;
      if (sum_valid)
      begin
        phase_idx   <= wrap ? '0 : phase_idx + 1'b1;
        sweep_start <= wrap;
      end
    end
  end

  ////////////////////
  // sweep found flag

  always_ff @(posedge alg_clk or negedge alg_rst_n)
  begin
    if (!alg_rst_n)
    begin
      sweep_found   <= 1'b0;
      sweep_found_q <= 1'b0;
    end
    else
    begin
      sweep_found_q <= sweep_found;
      if (frame_done && sweep_start)        // closing frame reopened the sweep
        sweep_found <= 1'b1;
      else if (research)
        sweep_found <= 1'b0;
    end
  end

  assign sweep_found_pulse = sweep_found & ~sweep_found_q;

  phase_in_range: assert property (@(posedge alg_clk) disable iff (!alg_rst_n)
    phase_idx < PHASE_STEPS);

endmodule

`default_nettype wire

// File: logic/mix_max_search.sv
`timescale 1ns/100ps
`default_nettype none

module mix_max_search #(
  parameter int PHASE_STEPS = 3600
) (
  input  wire                            alg_clk,
  input  wire                            alg_rst_n,
  input  wire                            research,
  input  wire                            sine_valid,
  input  wire mix_search_pkg::ref_t      sine_wave,
  input  wire                            cosine_valid,
  input  wire mix_search_pkg::ref_t      cosine_wave,
  input  wire mix_search_pkg::sample_t   capture_raw_dat,
  output wire                            search_req,
  output wire mix_search_pkg::addr_t     search_addr,
  output wire mix_search_pkg::extremum_t sine_extremum,
  output wire mix_search_pkg::extremum_t cosine_extremum,
  output wire                            frame_done,
  output wire                            init_phase_found_pulse
);

  wire mix_search_pkg::mix_beat_t  beat;
  wire mix_search_pkg::frame_sum_t sine_sum;
  wire mix_search_pkg::frame_sum_t cosine_sum;
  wire mix_search_pkg::phase_t     phase_idx;
  wire                             sweep_start;

  ////////////////////
  // mixing and sums

  ref_mixer mixer (
    .alg_clk         (alg_clk),
    .alg_rst_n       (alg_rst_n),
    .sine_valid      (sine_valid),
    .cosine_valid    (cosine_valid),
    .sine_wave       (sine_wave),
    .cosine_wave     (cosine_wave),
    .capture_raw_dat (capture_raw_dat),
    .search_req      (search_req),
    .search_addr     (search_addr),
    .beat            (beat)
  );

  product_accumulator sine_acc (
    .alg_clk    (alg_clk),
    .alg_rst_n  (alg_rst_n),
    .beat_valid (beat.valid),
    .beat_sof   (beat.sof),
    .beat_eof   (beat.eof),
    .prod       (beat.sine_prod),
    .frame_sum  (sine_sum)
  );

  product_accumulator cosine_acc (
    .alg_clk    (alg_clk),
    .alg_rst_n  (alg_rst_n),
    .beat_valid (beat.valid),
    .beat_sof   (beat.sof),
    .beat_eof   (beat.eof),
    .prod       (beat.cosine_prod),
    .frame_sum  (cosine_sum)
  );

  ////////////////////
  // search

  extremum_tracker sine_track (
    .alg_clk     (alg_clk),
    .alg_rst_n   (alg_rst_n),
    .frame_sum   (sine_sum),
    .phase_idx   (phase_idx),
    .sweep_start (sweep_start),
    .extremum    (sine_extremum)
  );

  extremum_tracker cosine_track (
    .alg_clk     (alg_clk),
    .alg_rst_n   (alg_rst_n),
    .frame_sum   (cosine_sum),
    .phase_idx   (phase_idx),
    .sweep_start (sweep_start),
    .extremum    (cosine_extremum)
  );

  // both sums land together, cosine paces the sweep
  phase_sweep_ctrl #(
    .PHASE_STEPS (PHASE_STEPS)
  ) sweep_ctrl (
    .alg_clk           (alg_clk),
    .alg_rst_n         (alg_rst_n),
    .sum_valid         (cosine_sum.valid),
    .research          (research),
    .phase_idx         (phase_idx),
    .sweep_start       (sweep_start),
    .frame_done        (frame_done),
    .sweep_found_pulse (init_phase_found_pulse)
  );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 4
) (
  output logic alg_clk,
  output logic alg_rst_n
);

  initial
  begin
    alg_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) alg_clk = ~alg_clk;
  end

  // reset drops on a rising edge, clear of the sampling negedge
  initial
  begin
    alg_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge alg_clk);
    alg_rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: testbench/tb_mix_max_search.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mix_max_search;

  localparam int STEPS = 8;

  wire                                alg_clk;
  wire                                alg_rst_n;
  logic                               research;
  logic                               sine_valid;
  logic                               cosine_valid;
  mix_search_pkg::ref_t               sine_wave;
  mix_search_pkg::ref_t               cosine_wave;
  mix_search_pkg::sample_t            capture_raw_dat = '0;
  wire                                search_req;
  wire mix_search_pkg::addr_t         search_addr;
  wire mix_search_pkg::extremum_t     sine_extremum;
  wire mix_search_pkg::extremum_t     cosine_extremum;
  wire                                frame_done;
  wire                                init_phase_found_pulse;

  mix_search_pkg::sample_t   sample_mem [0:511];  // capture memory model
  mix_search_pkg::ref_t      sine_ref [0:511];
  mix_search_pkg::ref_t      cos_ref [0:511];
  mix_search_pkg::sum_t      model_max [2];
  mix_search_pkg::sum_t      model_min [2];
  mix_search_pkg::extremum_t model_ext [2];
  mix_search_pkg::extremum_t exp_sine_q [$];
  mix_search_pkg::extremum_t exp_cos_q [$];
  bit                        exp_pulse_q [$];
  logic [31:0] rng = 32'h0f79e8dd;
  bit          found_flag = 1'b0;            // model of the sticky found flag
  int          exp_phase = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          errors_at_start;
  int          pulses_at_start;
  int          pulse_count = 0;
  string       test_name = "reset";

  tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(4)) clk_gen (
    .alg_clk   (alg_clk),
    .alg_rst_n (alg_rst_n)
  );

  mix_max_search #(.PHASE_STEPS(STEPS)) dut (
    .alg_clk                (alg_clk),
    .alg_rst_n              (alg_rst_n),
    .research               (research),
    .sine_valid             (sine_valid),
    .sine_wave              (sine_wave),
    .cosine_valid           (cosine_valid),
    .cosine_wave            (cosine_wave),
    .capture_raw_dat        (capture_raw_dat),
    .search_req             (search_req),
    .search_addr            (search_addr),
    .sine_extremum          (sine_extremum),
    .cosine_extremum        (cosine_extremum),
    .frame_done             (frame_done),
    .init_phase_found_pulse (init_phase_found_pulse)
  );

  // read data comes back one cycle after the address
  always @(posedge alg_clk)
    capture_raw_dat <= sample_mem[search_addr];

  always @(negedge alg_clk)
    if (init_phase_found_pulse)
      pulse_count++;

  ////////////////////
  // reference model

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // exact signed sum of sample times reference over one frame
  function automatic mix_search_pkg::sum_t frame_sum_ref(input int n, input bit use_cos);
    mix_search_pkg::sum_t acc;
    mix_search_pkg::sum_t ref_word;
    acc = '0;
    for (int k = 0; k < n; k++)
    begin
      ref_word = use_cos ? mix_search_pkg::sum_t'(cos_ref[k])
                         : mix_search_pkg::sum_t'(sine_ref[k]);
      acc = acc + mix_search_pkg::sum_t'(sample_mem[k]) * ref_word;
    end
    return acc;
  endfunction

  task automatic model_frame(input int ch, input mix_search_pkg::sum_t s, input int phase);
    if (phase == 0 || s > model_max[ch])    // first frame of a sweep loads
    begin
      model_max[ch]         = s;
      model_ext[ch].max_pos = mix_search_pkg::phase_t'(phase);
    end
    if (phase == 0 || s < model_min[ch])
    begin
      model_min[ch]         = s;
      model_ext[ch].min_pos = mix_search_pkg::phase_t'(phase);
    end
  endtask

  ////////////////////
  // compare tasks

  task automatic check_ext(input string name, input mix_search_pkg::extremum_t exp_v,
                           input mix_search_pkg::extremum_t act);
    checks++;
    if (act !== exp_v)
    begin
      errors++;
      $display("FAIL %s expected max_pos=%0d min_pos=%0d actual max_pos=%0d min_pos=%0d",
               name, exp_v.max_pos, exp_v.min_pos, act.max_pos, act.min_pos);
    end
  endtask

  task automatic check_addr(input string name, input mix_search_pkg::addr_t exp_v,
                            input mix_search_pkg::addr_t act);
    checks++;
    if (act !== exp_v)
    begin
      errors++;
      $display("FAIL %s expected addr=%0d actual addr=%0d", name, exp_v, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act);
    checks++;
    if (act !== exp_v)
    begin
      errors++;
      $display("FAIL %s expected %b actual %b", name, exp_v, act);
    end
  endtask

  task automatic check_count(input string name, input int exp_v, input int act);
    checks++;
    if (act != exp_v)
    begin
      errors++;
      $display("FAIL %s expected %0d actual %0d", name, exp_v, act);
    end
  endtask

  // results land together with frame_done, the pulse one cycle later
  initial
  begin : compare_results
    bit pulse_exp;
    forever
    begin
      @(negedge alg_clk);
      if (frame_done && exp_sine_q.size() == 0)
      begin
        errors++;
        $display("ERROR: %s saw frame_done with no frame in flight", test_name);
      end
      else if (frame_done)
      begin
        check_ext({test_name, ".sine"}, exp_sine_q.pop_front(), sine_extremum);
        check_ext({test_name, ".cosine"}, exp_cos_q.pop_front(), cosine_extremum);
        pulse_exp = exp_pulse_q.pop_front();
        @(negedge alg_clk);
        check_bit({test_name, ".found_pulse"}, pulse_exp, init_phase_found_pulse);
      end
    end
  end

  ////////////////////
  // stimulus

  task automatic abort_on_timeout(input string what);
    $display("ERROR: test %s timed out, %s", test_name, what);
    $display("RESULT: FAIL");
    $finish;
  endtask

  task automatic fill_frame(input int n);
    logic [15:0] hi;
    for (int k = 0; k < n; k++)
    begin
      rng = xorshift32(rng);
      sample_mem[k] = mix_search_pkg::sample_t'(rng[15:0]);
      hi = rng[31:16];
      rng = xorshift32(rng);
      sine_ref[k] = mix_search_pkg::ref_t'({hi, rng});
      rng = xorshift32(rng);
      cos_ref[k] = mix_search_pkg::ref_t'({rng[31:16], xorshift32(rng)});
    end
  endtask

  task automatic run_frame(input int n, input bit refill);
    int cycles;
    if (refill)
      fill_frame(n);
    model_frame(0, frame_sum_ref(n, 1'b0), exp_phase);
    model_frame(1, frame_sum_ref(n, 1'b1), exp_phase);
    exp_sine_q.push_back(model_ext[0]);
    exp_cos_q.push_back(model_ext[1]);
    exp_pulse_q.push_back(exp_phase == STEPS - 1 && !found_flag);
    if (exp_phase == STEPS - 1)
      found_flag = 1'b1;
    exp_phase = (exp_phase + 1) % STEPS;
    for (int k = 0; k < n; k++)
    begin
      @(posedge alg_clk);
      sine_valid   <= 1'b1;
      cosine_valid <= 1'b1;
      sine_wave    <= sine_ref[k];
      cosine_wave  <= cos_ref[k];
      @(negedge alg_clk);
      check_bit({test_name, ".search_req"}, 1'b1, search_req);
      check_addr({test_name, ".search_addr"}, mix_search_pkg::addr_t'(k), search_addr);
    end
    @(posedge alg_clk);
    sine_valid   <= 1'b0;
    cosine_valid <= 1'b0;
    @(negedge alg_clk);
    check_bit({test_name, ".search_req"}, 1'b0, search_req);
    @(negedge alg_clk);
    check_addr({test_name, ".search_addr_idle"}, '0, search_addr);
    cycles = 0;
    while (!frame_done && cycles < 20)
    begin
      @(negedge alg_clk);
      cycles++;
    end
    if (!frame_done)
      abort_on_timeout("frame_done never came");
    else
    begin
      // two idle cycles already passed since the last beat
      check_count({test_name, ".frame_done_latency"}, 4, cycles + 2);
      repeat (2) @(posedge alg_clk);
    end
  endtask

  task automatic pulse_research();
    @(posedge alg_clk);
    research <= 1'b1;
    @(posedge alg_clk);
    research <= 1'b0;
    found_flag = 1'b0;
  endtask

  task automatic run_frames(input int count, input bit same_data, input int research_at);
    int n;
    rng = xorshift32(rng);
    n = 2 + int'(rng[4:0]);
    for (int f = 0; f < count; f++)
    begin
      if (f == research_at)
        pulse_research();
      if (!same_data)
      begin
        rng = xorshift32(rng);
        n = 2 + int'(rng[4:0]);
      end
      run_frame(n, !same_data || f == 0);
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    pulses_at_start = pulse_count;
  endtask

  task automatic end_test();
    tests++;
    if (errors == errors_at_start)
      $display("test %s: ok", test_name);
    else
      $display("test %s: %0d errors", test_name, errors - errors_at_start);
  endtask

  initial
  begin : stimulus
    int cycles;
    research     = 1'b0;
    sine_valid   = 1'b0;
    cosine_valid = 1'b0;
    sine_wave    = '0;
    cosine_wave  = '0;
    cycles = 0;
    while (!alg_rst_n && cycles < 20)
    begin
      @(posedge alg_clk);
      cycles++;
    end
    if (!alg_rst_n)
      abort_on_timeout("reset never released");

    start_test("addr_count");
    run_frame(12, 1'b1);
    end_test();

    start_test("found_pulse");
    run_frames(STEPS - 1, 1'b0, -1);
    check_count("found_pulse.pulses", 1, pulse_count - pulses_at_start);
    end_test();

    start_test("random_sweep");             // flag still set, so no new pulse
    run_frames(STEPS, 1'b0, -1);
    check_count("random_sweep.pulses", 0, pulse_count - pulses_at_start);
    end_test();

    start_test("equal_sums");
    run_frames(STEPS, 1'b1, -1);
    @(negedge alg_clk);
    check_ext("equal_sums.sine", '0, sine_extremum);
    check_ext("equal_sums.cosine", '0, cosine_extremum);
    end_test();

    start_test("research_mid_sweep");
    run_frames(STEPS, 1'b0, 3);
    check_count("research_mid_sweep.pulses", 1, pulse_count - pulses_at_start);
    end_test();

    // positions of the last sweep are spread, phase 0 must reload both
    start_test("first_frame_load");
    run_frames(1, 1'b0, -1);
    @(negedge alg_clk);
    check_ext("first_frame_load.sine", '0, sine_extremum);
    check_ext("first_frame_load.cosine", '0, cosine_extremum);
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: mix_max_search.f
logic/mix_search_pkg.sv
logic/ref_mixer.sv
logic/product_accumulator.sv
logic/extremum_tracker.sv
logic/phase_sweep_ctrl.sv
logic/mix_max_search.sv
testbench/tb_clock_gen.sv
testbench/tb_mix_max_search.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mix_max_search testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mix_max_search \
  --Mdir obj_dir \
  -f mix_max_search.f

./obj_dir/Vtb_mix_max_search | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
